// File: rtl/icache_pkg.sv
// Instruction cache package with geometry, address fields, write structs and FSM states
package icache_pkg;

   ////////////////////////////// Geometry
   localparam int unsigned FETCH_ADDR_W = 32;
   localparam int unsigned FETCH_DATA_W = 32;
   localparam int unsigned LINE_W       = 128;
   localparam int unsigned NB_WAYS      = 4;
   localparam int unsigned NB_SETS      = 16;
   localparam int unsigned WORD_OFS_W   = 2;
   localparam int unsigned SET_W        = 4;
   localparam int unsigned TAG_W        = 24;

   // Address split: tag [31:8], set [7:4], word [3:2]
   localparam int unsigned WORD_OFS_LSB = 2;
   localparam int unsigned SET_LSB      = WORD_OFS_LSB + WORD_OFS_W;
   localparam int unsigned TAG_LSB      = SET_LSB + SET_W;

   ////////////////////////////// Types
   typedef logic [FETCH_ADDR_W-1:0] fetch_addr_t;
   typedef logic [FETCH_DATA_W-1:0] fetch_word_t;
   typedef logic [LINE_W-1:0]       line_t;
   typedef logic [SET_W-1:0]        set_idx_t;
   typedef logic [TAG_W-1:0]        tag_t;
   typedef logic [NB_WAYS-1:0]      way_oh_t;

   typedef struct packed {
      way_oh_t  way_mask;  // Ways written, all zero means no write
      set_idx_t set_idx;
      logic     valid;
      tag_t     tag;
   } tag_wr_t;

   typedef struct packed {
      way_oh_t  way_mask;
      set_idx_t set_idx;
      line_t    line;
   } line_wr_t;

   typedef enum logic [3:0] {
      DISABLED,
      BYPASS_REFILL,
      BYPASS_WAIT,
      FLUSH,
      IDLE,
      LOOKUP,
      WAIT_GNT,
      WAIT_DONE
   } ctrl_state_e;

endpackage

// File: rtl/icache_way_select.sv
// Victim way selection by lowest free way or by LFSR when the set is full
`timescale 1ns/1ps

module icache_way_select
   import icache_pkg::*;
#(
   parameter int unsigned NB_WAYS   = icache_pkg::NB_WAYS,
   parameter logic [7:0]  LFSR_SEED = 8'hA5
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic [NB_WAYS-1:0] valid_ways_i,
   input  logic               pick_i,
   output logic [NB_WAYS-1:0] victim_way_o
);

   localparam int unsigned WAY_IDX_W = $clog2(NB_WAYS);

   logic [7:0]           lfsr_q;
   logic                 lfsr_fb;
   logic [NB_WAYS-1:0]   free_way;
   logic [NB_WAYS-1:0]   random_way;

   // x^8 + x^6 + x^5 + x^4 + 1
   assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         lfsr_q <= LFSR_SEED;
      else if (pick_i)
         lfsr_q <= {lfsr_q[6:0], lfsr_fb};
   end

   assign random_way = (NB_WAYS)'(1) << lfsr_q[WAY_IDX_W-1:0];

   // Walk down so the lowest invalid way wins
   always_comb
   begin
      free_way = '0;
      for (int w = NB_WAYS - 1; w >= 0; w--)
      begin
         if (!valid_ways_i[w])
         begin
            free_way    = '0;
            free_way[w] = 1'b1;
         end
      end
   end

   assign victim_way_o = (&valid_ways_i) ? random_way : free_way;

endmodule

// File: rtl/icache_tag_store.sv
// Tag and valid array with registered set read and per-way tag compare
`timescale 1ns/1ps

module icache_tag_store
   import icache_pkg::*;
#(
   parameter int unsigned NB_WAYS = icache_pkg::NB_WAYS,
   parameter int unsigned NB_SETS = icache_pkg::NB_SETS
)
(
   input  logic               clk,
   input  logic               rst_n,
   input  logic               rd_en_i,
   input  set_idx_t           rd_set_i,
   input  tag_wr_t            tag_wr_i,
   input  tag_t               cmp_tag_i,
   output logic [NB_WAYS-1:0] hit_ways_o,
   output logic [NB_WAYS-1:0] valid_ways_o
);

   logic [NB_SETS-1:0][NB_WAYS-1:0] valid_q;
   logic [NB_WAYS-1:0]              valid_rd_q;
   tag_t                            tag_mem [NB_SETS][NB_WAYS];
   tag_t                            tag_rd_q [NB_WAYS];

   // Valid bits
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         valid_q    <= '0;
         valid_rd_q <= '0;
      end
      else
      begin
         if (rd_en_i)
            valid_rd_q <= valid_q[rd_set_i];
         for (int w = 0; w < NB_WAYS; w++)
         begin
            if (tag_wr_i.way_mask[w])
               valid_q[tag_wr_i.set_idx][w] <= tag_wr_i.valid;
         end
      end
   end

   // Tag array
   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (tag_wr_i.way_mask[w])
            tag_mem[tag_wr_i.set_idx][w] <= tag_wr_i.tag;
         if (rd_en_i)
            tag_rd_q[w] <= tag_mem[rd_set_i][w];
      end
   end

   always_comb
   begin
      for (int w = 0; w < NB_WAYS; w++)
         hit_ways_o[w] = valid_rd_q[w] && (tag_rd_q[w] == cmp_tag_i);
   end

   assign valid_ways_o = valid_rd_q;

endmodule

// File: rtl/icache_data_store.sv
// Cache line array with registered set read and hit way and word selection
`timescale 1ns/1ps

module icache_data_store
   import icache_pkg::*;
#(
   parameter int unsigned NB_WAYS = icache_pkg::NB_WAYS,
   parameter int unsigned NB_SETS = icache_pkg::NB_SETS
)
(
   input  logic                  clk,
   input  logic                  rd_en_i,
   input  set_idx_t              rd_set_i,
   input  line_wr_t              line_wr_i,
   input  logic [NB_WAYS-1:0]    hit_ways_i,
   input  logic [WORD_OFS_W-1:0] word_ofs_i,
   output fetch_word_t           hit_word_o
);

   line_t line_mem [NB_SETS][NB_WAYS];
   line_t line_rd_q [NB_WAYS];
   line_t hit_line;

   always_ff @(posedge clk)
   begin
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (line_wr_i.way_mask[w])
            line_mem[line_wr_i.set_idx][w] <= line_wr_i.line;
         if (rd_en_i)
            line_rd_q[w] <= line_mem[rd_set_i][w];  // All ways of the set
      end
   end

   // Hit ways are one-hot, so an OR of the masked lines selects
   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < NB_WAYS; w++)
      begin
         if (hit_ways_i[w])
            hit_line = hit_line | line_rd_q[w];
      end
   end

   assign hit_word_o = hit_line[word_ofs_i*FETCH_DATA_W +: FETCH_DATA_W];

endmodule

// File: rtl/icache_ctrl.sv
// Instruction cache controller FSM for bypass, flush, lookup and line refill
`timescale 1ns/1ps

module icache_ctrl
   import icache_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst_n,

   input  logic                  fetch_req_i,
   input  fetch_addr_t           fetch_addr_i,
   output logic                  fetch_gnt_o,
   output logic                  fetch_rvalid_o,
   output fetch_word_t           fetch_rdata_o,

   input  logic                  bypass_icache_i,
   input  logic                  flush_icache_i,
   output logic                  cache_is_bypassed_o,
   output logic                  cache_is_flushed_o,

   output logic                  refill_req_o,
   output fetch_addr_t           refill_addr_o,
   input  logic                  refill_gnt_i,
   input  logic                  refill_rvalid_i,
   input  line_t                 refill_rdata_i,

   output logic                  tag_rd_en_o,
   output set_idx_t              rd_set_o,
   output tag_wr_t               tag_wr_o,
   input  way_oh_t               hit_ways_i,
   input  way_oh_t               valid_ways_i,

   output logic                  data_rd_en_o,
   output logic [WORD_OFS_W-1:0] word_ofs_o,
   output line_wr_t              line_wr_o,
   input  fetch_word_t           hit_word_i,

   output logic                  pick_o,
   input  way_oh_t               victim_way_i
);

   ctrl_state_e             state_q, state_d;
   fetch_addr_t             fetch_addr_q;
   way_oh_t                 victim_q;
   set_idx_t                flush_cnt_q, flush_cnt_d;
   logic                    addr_en;
   logic                    victim_en;
   logic                    hit;
   logic [WORD_OFS_W-1:0]   word_ofs;
   fetch_word_t             refill_word;

   assign hit           = |hit_ways_i;
   assign word_ofs      = fetch_addr_q[WORD_OFS_LSB +: WORD_OFS_W];
   assign word_ofs_o    = word_ofs;
   assign refill_addr_o = fetch_addr_q;     // Also the compare address of the tag store
   assign data_rd_en_o  = tag_rd_en_o;      // Tag and data read in lockstep
   assign refill_word   = refill_rdata_i[word_ofs*FETCH_DATA_W +: FETCH_DATA_W];

   // Response mux: hit word on lookup, forwarded refill word otherwise
   assign fetch_rdata_o = (state_q == LOOKUP) ? hit_word_i : refill_word;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q      <= DISABLED;
         fetch_addr_q <= '0;
         victim_q     <= '0;
         flush_cnt_q  <= '0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         if (addr_en)
            fetch_addr_q <= fetch_addr_i;
         if (victim_en)
            victim_q <= victim_way_i;
      end
   end

   ////////////////////////////// Next state and outputs
   always_comb
   begin
      state_d             = state_q;
      flush_cnt_d         = flush_cnt_q;
      addr_en             = 1'b0;
      victim_en           = 1'b0;
      fetch_gnt_o         = 1'b0;
      fetch_rvalid_o      = 1'b0;
      refill_req_o        = 1'b0;
      cache_is_bypassed_o = 1'b0;
      cache_is_flushed_o  = 1'b0;
      tag_rd_en_o         = 1'b0;
      rd_set_o            = fetch_addr_i[SET_LSB +: SET_W];
      pick_o              = 1'b0;

      tag_wr_o.way_mask   = '0;
      tag_wr_o.set_idx    = fetch_addr_q[SET_LSB +: SET_W];
      tag_wr_o.valid      = 1'b1;
      tag_wr_o.tag        = fetch_addr_q[TAG_LSB +: TAG_W];

      line_wr_o.way_mask  = '0;
      line_wr_o.set_idx   = fetch_addr_q[SET_LSB +: SET_W];
      line_wr_o.line      = refill_rdata_i;

      case (state_q)
         DISABLED:
         begin
            cache_is_bypassed_o = 1'b1;
            flush_cnt_d         = '0;
            if (bypass_icache_i)
            begin
               fetch_gnt_o = fetch_req_i;
               addr_en     = fetch_req_i;
               if (fetch_req_i)
                  state_d = BYPASS_REFILL;
            end
            else
               state_d = FLUSH;  // Enabling always starts clean
         end

         BYPASS_REFILL:
         begin
            cache_is_bypassed_o = 1'b1;
            refill_req_o        = 1'b1;
            if (refill_gnt_i)
               state_d = BYPASS_WAIT;
         end

         BYPASS_WAIT:
         begin
            cache_is_bypassed_o = 1'b1;
            fetch_rvalid_o      = refill_rvalid_i;  // Single beat
            if (refill_rvalid_i)
               state_d = DISABLED;
         end

         FLUSH:
         begin
            // Invalidate every way of one set per cycle
            tag_wr_o.way_mask = '1;
            tag_wr_o.set_idx  = flush_cnt_q;
            tag_wr_o.valid    = 1'b0;
            tag_wr_o.tag      = '0;
            if (flush_cnt_q == set_idx_t'(NB_SETS - 1))
            begin
               cache_is_flushed_o = 1'b1;
               flush_cnt_d        = '0;
               state_d            = IDLE;
            end
            else
               flush_cnt_d = flush_cnt_q + 1'b1;
         end

         IDLE:
         begin
            if (bypass_icache_i)
               state_d = DISABLED;
            else if (flush_icache_i)
               state_d = FLUSH;
            else
            begin
               fetch_gnt_o = fetch_req_i;
               addr_en     = fetch_req_i;
               tag_rd_en_o = fetch_req_i;
               if (fetch_req_i)
                  state_d = LOOKUP;
            end
         end

         LOOKUP:
         begin
            if (hit)
            begin
               fetch_rvalid_o = 1'b1;
               // Next request overlaps this response
               if (!bypass_icache_i && !flush_icache_i)
               begin
                  fetch_gnt_o = fetch_req_i;
                  addr_en     = fetch_req_i;
                  tag_rd_en_o = fetch_req_i;
               end
               if (!fetch_gnt_o)
                  state_d = IDLE;
            end
            else
            begin
               refill_req_o = 1'b1;
               victim_en    = 1'b1;
               pick_o       = &valid_ways_i;  // Random choice only when the set is full
               state_d      = refill_gnt_i ? WAIT_DONE : WAIT_GNT;
            end
         end

         WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
               state_d = WAIT_DONE;
         end

         WAIT_DONE:
         begin
            fetch_rvalid_o     = refill_rvalid_i;
            tag_wr_o.way_mask  = victim_q & {NB_WAYS{refill_rvalid_i}};
            line_wr_o.way_mask = victim_q & {NB_WAYS{refill_rvalid_i}};
            if (refill_rvalid_i)
               state_d = IDLE;
         end

         default:
         begin
            state_d = DISABLED;
         end
      endcase
   end

endmodule

// File: rtl/icache_top.sv
// Instruction cache top level connecting controller, tag and data arrays and victim picker
`timescale 1ns/1ps

module icache_top
   import icache_pkg::*;
#(
   parameter int unsigned NB_WAYS = icache_pkg::NB_WAYS,
   parameter int unsigned NB_SETS = icache_pkg::NB_SETS
)
(
   input  logic        clk,
   input  logic        rst_n,

   // Processor fetch port
   input  logic        fetch_req_i,
   input  fetch_addr_t fetch_addr_i,
   output logic        fetch_gnt_o,
   output logic        fetch_rvalid_o,
   output fetch_word_t fetch_rdata_o,

   // Mode control
   input  logic        bypass_icache_i,
   input  logic        flush_icache_i,
   output logic        cache_is_bypassed_o,
   output logic        cache_is_flushed_o,

   // Refill port
   output logic        refill_req_o,
   output fetch_addr_t refill_addr_o,
   input  logic        refill_gnt_i,
   input  logic        refill_rvalid_i,
   input  line_t       refill_rdata_i
);

   logic                  tag_rd_en;
   logic                  data_rd_en;
   set_idx_t              rd_set;
   tag_wr_t               tag_wr;
   line_wr_t              line_wr;
   way_oh_t               hit_ways;
   way_oh_t               valid_ways;
   fetch_word_t           hit_word;
   logic [WORD_OFS_W-1:0] word_ofs;
   logic                  pick;
   way_oh_t               victim_way;
   tag_t                  cmp_tag;

   assign cmp_tag = refill_addr_o[TAG_LSB +: TAG_W];  // Tag of the registered fetch address

   icache_ctrl u_ctrl (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req_i),
      .fetch_addr_i        (fetch_addr_i),
      .fetch_gnt_o         (fetch_gnt_o),
      .fetch_rvalid_o      (fetch_rvalid_o),
      .fetch_rdata_o       (fetch_rdata_o),
      .bypass_icache_i     (bypass_icache_i),
      .flush_icache_i      (flush_icache_i),
      .cache_is_bypassed_o (cache_is_bypassed_o),
      .cache_is_flushed_o  (cache_is_flushed_o),
      .refill_req_o        (refill_req_o),
      .refill_addr_o       (refill_addr_o),
      .refill_gnt_i        (refill_gnt_i),
      .refill_rvalid_i     (refill_rvalid_i),
      .refill_rdata_i      (refill_rdata_i),
      .tag_rd_en_o         (tag_rd_en),
      .rd_set_o            (rd_set),
      .tag_wr_o            (tag_wr),
      .hit_ways_i          (hit_ways),
      .valid_ways_i        (valid_ways),
      .data_rd_en_o        (data_rd_en),
      .word_ofs_o          (word_ofs),
      .line_wr_o           (line_wr),
      .hit_word_i          (hit_word),
      .pick_o              (pick),
      .victim_way_i        (victim_way)
   );

   icache_tag_store #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_tag_store (
      .clk          (clk),
      .rst_n        (rst_n),
      .rd_en_i      (tag_rd_en),
      .rd_set_i     (rd_set),
      .tag_wr_i     (tag_wr),
      .cmp_tag_i    (cmp_tag),
      .hit_ways_o   (hit_ways),
      .valid_ways_o (valid_ways)
   );

   icache_data_store #(
      .NB_WAYS (NB_WAYS),
      .NB_SETS (NB_SETS)
   ) u_data_store (
      .clk        (clk),
      .rd_en_i    (data_rd_en),
      .rd_set_i   (rd_set),
      .line_wr_i  (line_wr),
      .hit_ways_i (hit_ways),
      .word_ofs_i (word_ofs),
      .hit_word_o (hit_word)
   );

   icache_way_select #(
      .NB_WAYS (NB_WAYS)
   ) u_way_select (
      .clk          (clk),
      .rst_n        (rst_n),
      .valid_ways_i (valid_ways),
      .pick_i       (pick),
      .victim_way_o (victim_way)
   );

endmodule

// File: sim/l2_model.sv
// L2 refill memory model with random grant delay and line data computed from the address
`timescale 1ns/1ps

module l2_model
   import icache_pkg::*;
#(
   parameter logic [31:0] SEED = 32'h1
)
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        refill_req_i,
   input  fetch_addr_t refill_addr_i,
   output logic        refill_gnt_o,
   output logic        refill_rvalid_o,
   output line_t       refill_rdata_o
);

   integer      seed;
   int unsigned delay_v;
   int unsigned delay_q;
   logic        delay_set_q;
   fetch_addr_t addr_q;

   // Word n holds its own word address XOR a fixed pattern
   function automatic line_t line_for(input fetch_addr_t addr);
      line_t       line;
      fetch_addr_t base;
      base = {addr[31:4], 4'h0};
      for (int n = 0; n < 4; n++)
         line[n*FETCH_DATA_W +: FETCH_DATA_W] = (base + 32'(4 * n)) ^ 32'hA5A5_0000;
      return line;
   endfunction

   initial seed = SEED;

   // Outputs change on the falling edge like every other DUT input
   always @(negedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         refill_gnt_o    <= 1'b0;
         refill_rvalid_o <= 1'b0;
         refill_rdata_o  <= '0;
         addr_q          <= '0;
         delay_q         <= 0;
         delay_set_q     <= 1'b0;
      end
      else
      begin
         refill_rvalid_o <= 1'b0;
         if (refill_gnt_o)
         begin
            // Grant was taken on the last rising edge, single beat follows
            refill_gnt_o    <= 1'b0;
            refill_rvalid_o <= 1'b1;
            refill_rdata_o  <= line_for(addr_q);
         end
         else if (refill_req_i)
         begin
            if (!delay_set_q)
               delay_v = $unsigned($random(seed)) % 4;  // 0 to 3 cycles
            else
               delay_v = delay_q;
            if (delay_v == 0)
            begin
               refill_gnt_o <= 1'b1;
               addr_q       <= refill_addr_i;
               delay_set_q  <= 1'b0;
            end
            else
            begin
               delay_q     <= delay_v - 1;
               delay_set_q <= 1'b1;
            end
         end
      end
   end

endmodule

// File: sim/tb_icache.sv
// Testbench for the instruction cache with fetch driver, L2 model and protocol assertions
`timescale 1ns/1ps

module tb_icache
   import icache_pkg::*;
();

   localparam int          TMO  = 50;  // Cycles allowed per wait
   localparam logic [31:0] SEED = 32'h518ad2f4;

   logic        clk = 1'b0;
   logic        rst_n;
   logic        fetch_req;
   fetch_addr_t fetch_addr;
   logic        fetch_gnt;
   logic        fetch_rvalid;
   fetch_word_t fetch_rdata;
   logic        bypass;
   logic        flush;
   logic        is_bypassed;
   logic        is_flushed;
   logic        refill_req;
   fetch_addr_t refill_addr;
   logic        refill_gnt;
   logic        refill_rvalid;
   line_t       refill_rdata;

   fetch_addr_t exp_addr [256];       // Granted addresses in order
   fetch_addr_t last_gnt_addr = '0;
   fetch_word_t exp_rdata;
   int unsigned gnt_cnt = 0;
   int unsigned rsp_cnt = 0;
   int unsigned refill_cnt = 0;
   int unsigned stall_cnt = 0;
   int unsigned flushed_cnt = 0;
   logic        flush_armed;          // No grant until the flushed pulse
   logic        hit_phase;            // Fetches here must hit
   int          err_cnt = 0;
   int          test_err_base = 0;
   int          tests_run = 0;
   int          tests_failed = 0;

   always #20 clk = ~clk;

   icache_top DUT (
      .clk                 (clk),
      .rst_n               (rst_n),
      .fetch_req_i         (fetch_req),
      .fetch_addr_i        (fetch_addr),
      .fetch_gnt_o         (fetch_gnt),
      .fetch_rvalid_o      (fetch_rvalid),
      .fetch_rdata_o       (fetch_rdata),
      .bypass_icache_i     (bypass),
      .flush_icache_i      (flush),
      .cache_is_bypassed_o (is_bypassed),
      .cache_is_flushed_o  (is_flushed),
      .refill_req_o        (refill_req),
      .refill_addr_o       (refill_addr),
      .refill_gnt_i        (refill_gnt),
      .refill_rvalid_i     (refill_rvalid),
      .refill_rdata_i      (refill_rdata)
   );

   l2_model #(
      .SEED (SEED)
   ) u_l2 (
      .clk             (clk),
      .rst_n           (rst_n),
      .refill_req_i    (refill_req),
      .refill_addr_i   (refill_addr),
      .refill_gnt_o    (refill_gnt),
      .refill_rvalid_o (refill_rvalid),
      .refill_rdata_o  (refill_rdata)
   );

   // Word address with the line offset cleared, plus 4n, XOR the pattern
   function automatic fetch_word_t word_for(input fetch_addr_t addr);
      fetch_addr_t line_base;
      line_base = {addr[31:4], 4'h0};
      return (line_base + {28'd0, addr[3:2], 2'b00}) ^ 32'hA5A5_0000;
   endfunction

   assign exp_rdata = word_for(exp_addr[rsp_cnt[7:0]]);

   ////////////////////////////// Scoreboard
   always @(posedge clk)
   begin
      if (rst_n)
      begin
         if (fetch_req && fetch_gnt)
         begin
            exp_addr[gnt_cnt[7:0]] <= fetch_addr;
            last_gnt_addr          <= fetch_addr;
            gnt_cnt                <= gnt_cnt + 1;
         end
         if (fetch_rvalid)
            rsp_cnt <= rsp_cnt + 1;
         if (refill_req && refill_gnt)
            refill_cnt <= refill_cnt + 1;
         if (refill_req && !refill_gnt)
            stall_cnt <= stall_cnt + 1;
         if (is_flushed)
            flushed_cnt <= flushed_cnt + 1;
      end
   end

   task automatic report_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      err_cnt++;
      $display("[ERROR] %s got 0x%08h expected 0x%08h at %0t ns", name, got, exp, $time);
   endtask

   task automatic report_issue(input string msg);
      err_cnt++;
      $display("At %0t ns: %s", $time, msg);
   endtask

   ////////////////////////////// Assertions
   assert property (@(posedge clk) disable iff (!rst_n) fetch_rvalid |-> rsp_cnt != gnt_cnt)
   else report_issue("Fetch response arrived without an outstanding fetch");

   assert property (@(posedge clk) disable iff (!rst_n) fetch_rvalid |-> fetch_rdata == exp_rdata)
   else report_value("fetch_rdata_o", $sampled(fetch_rdata), $sampled(exp_rdata));

   assert property (@(posedge clk) disable iff (!rst_n)
      (bypass && fetch_req && fetch_gnt) |=> refill_req)
   else report_issue("Bypass fetch was not followed by a refill request");

   assert property (@(posedge clk) disable iff (!rst_n)
      (bypass && fetch_req && fetch_gnt) |-> is_bypassed)
   else report_issue("Bypass fetch granted while the cache was not bypassed");

   assert property (@(posedge clk) disable iff (!rst_n) refill_req |-> refill_addr == last_gnt_addr)
   else report_value("refill_addr_o", $sampled(refill_addr), $sampled(last_gnt_addr));

   assert property (@(posedge clk) disable iff (!rst_n) flush_armed |-> !fetch_gnt)
   else report_issue("Fetch granted before the flush completed");

   assert property (@(posedge clk) disable iff (!rst_n)
      (hit_phase && fetch_req && fetch_gnt) |=> fetch_rvalid)
   else report_issue("Hit response did not follow its grant by one cycle");

   // A fetch waiting during a hit response is granted in that same cycle
   assert property (@(posedge clk) disable iff (!rst_n)
      (hit_phase && fetch_req && fetch_rvalid) |-> fetch_gnt)
   else report_issue("Fetch pending during a hit response was not granted with it");

   assert property (@(posedge clk) disable iff (!rst_n) hit_phase |-> !refill_req)
   else report_issue("Refill requested for a fetch that should hit");

   // Stalled request holds and no response slips out
   assert property (@(posedge clk) disable iff (!rst_n)
      (refill_req && !refill_gnt) |=> refill_req && $stable(refill_addr) && !fetch_rvalid)
   else report_issue("Refill request changed or a response appeared during a stall");

   ////////////////////////////// Stimulus tasks
   task automatic fetch_one(input fetch_addr_t addr);
      int unsigned base;
      int          t;
      base       = gnt_cnt;
      t          = 0;
      fetch_req  = 1'b1;
      fetch_addr = addr;
      do
      begin
         @(negedge clk);
         t++;
      end
      while (gnt_cnt == base && t < TMO);
      if (gnt_cnt == base)
         report_issue("Timeout waiting for a fetch grant");
   endtask

   task automatic wait_responses();
      int t;
      t = 0;
      while (rsp_cnt != gnt_cnt && t < TMO)
      begin
         @(negedge clk);
         t++;
      end
      if (rsp_cnt != gnt_cnt)
         report_issue("Timeout waiting for fetch responses");
   endtask

   task automatic fetch_and_wait(input fetch_addr_t addr);
      fetch_one(addr);
      fetch_req = 1'b0;
      wait_responses();
   endtask

   // Start a flush by enable or by request, hold a fetch across it, expect a refill after
   task automatic flush_then_fetch(input fetch_addr_t addr, input logic by_enable);
      int unsigned flush_base;
      int unsigned ref_base;
      int          t;
      flush_base  = flushed_cnt;
      ref_base    = refill_cnt;
      flush_armed = 1'b1;
      fetch_req   = 1'b1;
      fetch_addr  = addr;
      if (by_enable)
         bypass = 1'b0;
      else
         flush = 1'b1;
      @(negedge clk);
      flush = 1'b0;
      t     = 1;
      while (flushed_cnt == flush_base && t < NB_SETS + 4)
      begin
         @(negedge clk);
         t++;
      end
      if (flushed_cnt == flush_base)
         report_issue("cache_is_flushed_o did not pulse within the flush time");
      flush_armed = 1'b0;
      fetch_and_wait(addr);
      assert (refill_cnt == ref_base + 1)
      else report_value("refill count", refill_cnt, ref_base + 1);
   endtask

   task automatic end_test(input string name);
      tests_run++;
      if (err_cnt == test_err_base)
         $display("Test %0d %s: ok", tests_run, name);
      else
      begin
         tests_failed++;
         $display("Test %0d %s: failed with %0d errors", tests_run, name, err_cnt - test_err_base);
      end
      test_err_base = err_cnt;
   endtask

   ////////////////////////////// Test sequence
   initial
   begin
      int unsigned ref_base;
      int unsigned stall_base;
      rst_n       = 1'b0;
      fetch_req   = 1'b0;
      fetch_addr  = '0;
      bypass      = 1'b1;
      flush       = 1'b0;
      flush_armed = 1'b0;
      hit_phase   = 1'b0;
      repeat (2) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);

      ref_base = refill_cnt;
      for (int i = 0; i < 4; i++)
         fetch_and_wait(32'h0000_1004 + 32'(i) * 32'h0000_0144);
      assert (refill_cnt == ref_base + 4)
      else report_value("refill count", refill_cnt, ref_base + 4);
      end_test("bypass");

      flush_then_fetch(32'h0000_2048, 1'b1);
      end_test("enable flush");

      fetch_and_wait(32'h0000_4000);
      hit_phase = 1'b1;
      fetch_and_wait(32'h0000_4008);
      for (int i = 0; i < 4; i++)
         fetch_one(32'h0000_4000 + 32'(4 * i));  // One grant per cycle
      fetch_req = 1'b0;
      wait_responses();
      hit_phase = 1'b0;
      end_test("hits");

      // Five tags into set 3
      for (int k = 0; k < 5; k++)
         fetch_and_wait(32'h0001_0030 + 32'(k) * 32'h0001_0000 + 32'(4 * (k % 4)));
      hit_phase = 1'b1;
      fetch_and_wait(32'h0005_003C);
      hit_phase = 1'b0;
      end_test("replacement");

      flush_then_fetch(32'h0000_4004, 1'b0);
      end_test("flush request");

      stall_base = stall_cnt;
      for (int k = 0; k < 8; k++)
         fetch_and_wait(32'h0008_0000 + 32'(k) * 32'h0000_1050);
      assert (stall_cnt > stall_base)
      else report_issue("No stalled refill grant was seen");
      end_test("refill stall");

      $display("Tests: %0d run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
      if (err_cnt == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// File: all.f
rtl/icache_pkg.sv
rtl/icache_way_select.sv
rtl/icache_tag_store.sv
rtl/icache_data_store.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
sim/l2_model.sv
sim/tb_icache.sv

// File: Makefile
# Verilator build and run for the instruction cache testbench

VERILATOR ?= verilator
TOP       ?= tb_icache
RTL_TOP   ?= icache_top
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^>>> PASS$$" $(LOG) && echo "Simulation passed" || (echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only -Wall rtl/icache_pkg.sv rtl/icache_way_select.sv \
		rtl/icache_tag_store.sv rtl/icache_data_store.sv rtl/icache_ctrl.sv \
		rtl/icache_top.sv --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
